// ==== all.f ====
mag_pkg.sv
iter_counter.sv
mag_ctrl.sv
coef_mult_iter.sv
mag_datapath.sv
mag_estimator.sv
tb_mag_estimator.sv

// ==== tb_mag_estimator.sv ====
/* Directed testbench for the magnitude estimator.
   Each test drives the valid/ready ports and checks against a reference model. */

`timescale 1ns/10ps

module tb_mag_estimator;

  import mag_pkg::*;

  localparam int DATA_W  = 16;
  localparam int TIMEOUT = 60;          // Cycles allowed for any single wait.
  localparam int LATENCY = FRAC_W + 1;  // Rising edges until send_val, accept edge included.

  logic                clk;
  logic                reset;
  logic                recv_val;
  logic                recv_rdy;
  logic [2*DATA_W-1:0] recv_msg;
  logic                send_rdy;
  logic                send_val;
  logic [DATA_W:0]     send_msg;

  integer seed;
  int     items_done;

  mag_estimator #(
    .DATA_W (DATA_W)
  ) u_dut (
    .clk      (clk),
    .reset    (reset),
    .recv_val (recv_val),
    .recv_rdy (recv_rdy),
    .recv_msg (recv_msg),
    .send_rdy (send_rdy),
    .send_val (send_val),
    .send_msg (send_msg)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  // Reference: floor(max * 245 / 256) + floor(min * 101 / 256).
  function automatic logic [DATA_W:0] ref_mag(input logic [DATA_W-1:0] a,
                                              input logic [DATA_W-1:0] b);
    int unsigned mx;
    int unsigned mn;
    int unsigned sum;
    if (a >= b) begin
      mx = a;
      mn = b;
    end else begin
      mx = b;
      mn = a;
    end
    sum = (mx * 245) / 256 + (mn * 101) / 256;
    return sum[DATA_W:0];
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("CHECK FAILED at %0t ns: %s expected %0d, got %0d",
               $time, name, expected, actual);
      $display("*** FAILED ***");
      $fatal(1, "Stopping on first mismatch.");
    end
  endtask

  task automatic report_timeout(input string what);
    mag_state_e state_now;
    state_now = u_dut.u_ctrl.state;
    $display("Timeout at %0t ns: %s never arrived, controller in state %s.",
             $time, what, state_now.name());
    $display("*** FAILED ***");
    $fatal(1, "Stopping on handshake timeout.");
  endtask

  // Outputs are sampled and inputs driven 1 ns after each rising edge.
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // Offer one item and return just after its accept edge.
  task automatic send_item(input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b);
    int waited;
    waited   = 0;
    recv_msg = {a, b};
    recv_val = 1'b1;
    while (!recv_rdy) begin
      next_cycle();
      waited++;
      if (waited > TIMEOUT) begin
        report_timeout("recv_rdy for a new item");
      end
    end
    next_cycle();  // Accept edge.
    recv_val = 1'b0;
  endtask

  // One full item: accept, latency, back-pressure hold, send transfer.
  // With decoy set, a second item is offered while the result is held.
  task automatic run_item(input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b,
                          input int hold, input bit decoy,
                          output logic [DATA_W:0] result);
    int               edges;
    logic [DATA_W:0]  held;
    send_rdy = 1'b0;
    send_item(a, b);
    edges = 1;  // The accept edge counts as the first.
    while (!send_val) begin
      check_value("recv_rdy while busy", 0, recv_rdy);
      next_cycle();
      edges++;
      if (edges > TIMEOUT) begin
        report_timeout("send_val for the result");
      end
    end
    check_value("latency in edges", LATENCY, edges);
    check_value("send_msg", ref_mag(a, b), send_msg);
    held = send_msg;
    for (int i = 0; i < hold; i++) begin
      if (decoy) begin
        recv_val = 1'b1;
        recv_msg = ~{a, b};
      end
      next_cycle();
      check_value("send_val under back-pressure", 1, send_val);
      check_value("send_msg under back-pressure", held, send_msg);
      check_value("recv_rdy under back-pressure", 0, recv_rdy);
    end
    recv_val = 1'b0;
    send_rdy = 1'b1;
    next_cycle();  // Send transfer edge.
    send_rdy = 1'b0;
    check_value("send_val after transfer", 0, send_val);
    check_value("recv_rdy after transfer", 1, recv_rdy);
    result = held;
    items_done++;
  endtask

  task automatic test_reset_state();
    for (int i = 0; i < 6; i++) begin
      check_value("recv_rdy after reset", 1, recv_rdy);
      check_value("send_val after reset", 0, send_val);
      next_cycle();
    end
    $display("Reset state test done.");
  endtask

  task automatic test_directed();
    logic [DATA_W-1:0] a_list [10];
    logic [DATA_W-1:0] b_list [10];
    logic [DATA_W:0]   r_ab;
    logic [DATA_W:0]   r_ba;
    a_list = '{16'd1000, 16'd300, 16'd500, 16'd0, 16'd777,
               16'd0,    16'd1,   16'd255, 16'd40000, 16'd12345};
    b_list = '{16'd300,  16'd1000, 16'd500, 16'd777, 16'd0,
               16'd0,    16'd1,    16'd256, 16'd30000, 16'd54321};
    for (int i = 0; i < 10; i++) begin
      run_item(a_list[i], b_list[i], 0, 1'b0, r_ab);
      run_item(b_list[i], a_list[i], 1, 1'b0, r_ba);
      check_value("swapped result", r_ab, r_ba);
    end
    $display("Directed value test done.");
  endtask

  task automatic test_extremes();
    logic [DATA_W:0] r;
    run_item(16'hffff, 16'hffff, 0, 1'b0, r);
    check_value("send_msg top bit", 1, r[DATA_W]);
    check_value("send_msg at full scale", 17'd88574, r);
    run_item(16'hffff, 16'h0000, 0, 1'b0, r);
    check_value("max only result", ref_mag(16'hffff, 16'h0000), r);
    run_item(16'h0000, 16'hffff, 2, 1'b0, r);
    check_value("min first result", ref_mag(16'hffff, 16'h0000), r);
    $display("Extreme value test done.");
  endtask

  task automatic test_latency();
    logic [DATA_W:0] r;
    // run_item measures the edge count; two items back to back here.
    run_item(16'd4321, 16'd1234, 0, 1'b0, r);
    run_item(16'd1234, 16'd4321, 0, 1'b0, r);
    $display("Latency test done.");
  endtask

  task automatic test_backpressure();
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    logic [DATA_W:0]   r;
    int                hold;
    for (int i = 0; i < 12; i++) begin
      a    = $random(seed);
      b    = $random(seed);
      hold = $unsigned($random(seed)) % 21;
      run_item(a, b, hold, 1'b1, r);
    end
    $display("Back-pressure test done.");
  endtask

  task automatic test_random_stream();
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    logic [DATA_W:0]   r;
    int                hold;
    for (int i = 0; i < 200; i++) begin
      a    = $random(seed);
      b    = $random(seed);
      hold = $unsigned($random(seed)) % 5;
      run_item(a, b, hold, 1'b0, r);
    end
    $display("Random stream test done.");
  endtask

  initial begin
    seed       = 32'ha12b_c0c7;
    items_done = 0;
    reset      = 1'b1;
    recv_val   = 1'b0;
    recv_msg   = '0;
    send_rdy   = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    reset = 1'b0;

    test_reset_state();
    test_directed();
    test_extremes();
    test_latency();
    test_backpressure();
    test_random_stream();

    $display("%0d items checked.", items_done);
    $display("*** PASSED ***");
    $finish;
  end

endmodule

// ==== mag_estimator.sv ====
/* Top level of the streaming alpha-max-plus-beta-min magnitude estimator.
   Input word is {a, b}; the result is one bit wider than a component. */

`timescale 1ns/10ps

module mag_estimator #(
  parameter int DATA_W = 16
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                recv_val,
  output logic                recv_rdy,
  input  logic [2*DATA_W-1:0] recv_msg,
  input  logic                send_rdy,
  output logic                send_val,
  output logic [DATA_W:0]     send_msg
);

  import mag_pkg::*;

  mult_ctrl_t mult_ctrl;
  logic       start;
  logic       last;

  mag_ctrl u_ctrl (
    .clk       (clk),
    .reset     (reset),
    .recv_val  (recv_val),
    .recv_rdy  (recv_rdy),
    .send_rdy  (send_rdy),
    .send_val  (send_val),
    .last      (last),
    .start     (start),
    .mult_ctrl (mult_ctrl)
  );

  iter_counter #(
    .COUNT (FRAC_W)
  ) u_counter (
    .clk   (clk),
    .reset (reset),
    .start (start),
    .last  (last)
  );

  mag_datapath #(
    .DATA_W (DATA_W)
  ) u_datapath (
    .clk       (clk),
    .reset     (reset),
    .recv_msg  (recv_msg),
    .mult_ctrl (mult_ctrl),
    .last      (last),
    .send_msg  (send_msg)
  );

endmodule

// ==== mag_datapath.sv ====
/* Datapath of the magnitude estimator.
   Sorts the two components, scales them by alpha and beta and registers the sum. */

`timescale 1ns/10ps

module mag_datapath #(
  parameter int DATA_W = 16
) (
  input  logic                clk,
  input  logic                reset,
  input  logic [2*DATA_W-1:0] recv_msg,
  input  mag_pkg::mult_ctrl_t mult_ctrl,
  input  logic                last,
  output logic [DATA_W:0]     send_msg
);

  import mag_pkg::*;

  logic [DATA_W-1:0] comp_a;
  logic [DATA_W-1:0] comp_b;
  logic [DATA_W-1:0] max_val;
  logic [DATA_W-1:0] min_val;
  logic [DATA_W-1:0] alpha_prod;
  logic [DATA_W-1:0] beta_prod;
  logic [DATA_W:0]   result;

  assign comp_a = recv_msg[2*DATA_W-1:DATA_W];
  assign comp_b = recv_msg[DATA_W-1:0];

  // Ties go to a as the larger.
  always_comb begin
    if (comp_a >= comp_b) begin
      max_val = comp_a;
      min_val = comp_b;
    end else begin
      max_val = comp_b;
      min_val = comp_a;
    end
  end

  coef_mult_iter #(
    .DATA_W (DATA_W),
    .COEF   (ALPHA_Q)
  ) u_alpha_mult (
    .clk     (clk),
    .reset   (reset),
    .ctrl    (mult_ctrl),
    .operand (max_val),
    .product (alpha_prod)
  );

  coef_mult_iter #(
    .DATA_W (DATA_W),
    .COEF   (BETA_Q)
  ) u_beta_mult (
    .clk     (clk),
    .reset   (reset),
    .ctrl    (mult_ctrl),
    .operand (min_val),
    .product (beta_prod)
  );

  // Captured on the edge that enters DONE, held until the next item.
  always_ff @(posedge clk) begin
    if (mult_ctrl.step && last) begin
      result <= {1'b0, alpha_prod} + {1'b0, beta_prod};
    end
  end

  assign send_msg = result;

endmodule

// ==== coef_mult_iter.sv ====
/* Iterative multiplier of an unsigned operand by a constant Q0.8 coefficient.
   One coefficient bit per step, LSB first; the product drops the fraction bits. */

`timescale 1ns/10ps

module coef_mult_iter #(
  parameter int                         DATA_W = 16,
  parameter logic [mag_pkg::FRAC_W-1:0] COEF   = '0
) (
  input  logic                clk,
  input  logic                reset,
  input  mag_pkg::mult_ctrl_t ctrl,
  input  logic [DATA_W-1:0]   operand,
  output logic [DATA_W-1:0]   product
);

  import mag_pkg::*;

  localparam int ACC_W = DATA_W + FRAC_W;

  logic [ACC_W-1:0]  acc;
  logic [ACC_W-1:0]  acc_next;
  logic [ACC_W-1:0]  addend;     // Operand aligned to the current coefficient bit.
  logic [FRAC_W-1:0] coef_bits;  // Coefficient bits still to process.

  // Value of the accumulator once the iteration in progress completes.
  always_comb begin
    acc_next = acc;
    if (ctrl.step && coef_bits[0]) begin
      acc_next = acc + addend;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      coef_bits <= '0;
    end else if (ctrl.load) begin
      coef_bits <= COEF;
    end else if (ctrl.step) begin
      coef_bits <= coef_bits >> 1;
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.load) begin
      acc    <= '0;
      addend <= {{FRAC_W{1'b0}}, operand};
    end else if (ctrl.step) begin
      acc    <= acc_next;
      addend <= addend << 1;
    end
  end

  // Truncated, and already final during the last step.
  assign product = acc_next[ACC_W-1:FRAC_W];

endmodule

// ==== mag_ctrl.sv ====
/* Controller FSM for the magnitude estimator.
   Runs the receive and send handshakes and steers the counter and multipliers. */

`timescale 1ns/10ps

module mag_ctrl (
  input  logic                clk,
  input  logic                reset,
  input  logic                recv_val,
  output logic                recv_rdy,
  input  logic                send_rdy,
  output logic                send_val,
  input  logic                last,
  output logic                start,
  output mag_pkg::mult_ctrl_t mult_ctrl
);

  import mag_pkg::*;

  mag_state_e state;
  mag_state_e next_state;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state     = state;
    recv_rdy       = 1'b0;
    send_val       = 1'b0;
    start          = 1'b0;
    mult_ctrl.load = 1'b0;
    mult_ctrl.step = 1'b0;

    case (state)
      IDLE: begin
        recv_rdy = 1'b1;
        if (recv_val) begin
          start          = 1'b1;  // Counter and operands load on the accept edge.
          mult_ctrl.load = 1'b1;
          next_state     = CALC;
        end
      end
      CALC: begin
        mult_ctrl.step = 1'b1;
        if (last) begin
          next_state = DONE;
        end
      end
      DONE: begin
        send_val = 1'b1;  // Held until the result is taken.
        if (send_rdy) begin
          next_state = IDLE;
        end
      end
      default: begin
        next_state = IDLE;
      end
    endcase
  end

endmodule

// ==== iter_counter.sv ====
/* Iteration counter for the shift-and-add phase.
   Loaded by start, it counts down and flags the final iteration with last. */

`timescale 1ns/10ps

module iter_counter #(
  parameter int COUNT = mag_pkg::FRAC_W
) (
  input  logic clk,
  input  logic reset,
  input  logic start,
  output logic last
);

  localparam int CNT_W = $clog2(COUNT + 1);

  logic [CNT_W-1:0] count;

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (start) begin
      count <= CNT_W'(COUNT);
    end else if (count != '0) begin
      count <= count - CNT_W'(1);
    end
  end

  // High during the final iteration.
  assign last = (count == CNT_W'(1));

endmodule

// ==== mag_pkg.sv ====
/* Shared constants and types for the alpha-max-plus-beta-min magnitude estimator.
   Modules import it inside their bodies and use scoped names in their headers. */

package mag_pkg;

  // Fraction bits of the coefficients, also the multiply iteration count.
  localparam int FRAC_W = 8;

  // Coefficients in unsigned Q0.8.
  localparam logic [FRAC_W-1:0] ALPHA_Q = 8'd245;  // About 0.957.
  localparam logic [FRAC_W-1:0] BETA_Q  = 8'd101;  // About 0.395.

  // Controller states.
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    CALC = 2'd1,
    DONE = 2'd3
  } mag_state_e;

  // Control shared by both iterative multipliers.
  typedef struct packed {
    logic load;  // Clear accumulator and capture a new operand.
    logic step;  // One shift-and-add iteration.
  } mult_ctrl_t;

endpackage
